//--- rtl/halfFloatPkg.sv
// ------------------------------
// IEEE 754 binary16 format fields
// Subnormal encodings not handled
// ------------------------------
`default_nettype none

package halfFloatPkg;

    // Encoded value and its fields
    typedef logic [15:0] halfWord;
    typedef logic [4:0]  expField;
    typedef logic [9:0]  fracField;
    typedef logic [10:0] sigField;     // Hidden bit at [10]

    // Product of two significands, binary point after bit 20
    typedef logic [21:0] productSig;

    // Biased product exponent, may go negative or past 31
    typedef logic signed [5:0] productExp;

    // Aligned sum: carry at [23], data at [22:1], sticky at [0]
    typedef logic [23:0] sumSig;

    localparam int expBias = 15;

    localparam halfWord quietNan = 16'h7E00;   // Canonical quiet NaN

    // Magnitudes only, sign is prepended by the user
    localparam logic [14:0] maxFiniteMag = 15'h7BFF;
    localparam logic [14:0] infMag       = 15'h7C00;

endpackage

`default_nettype wire

//--- rtl/fmaTransferPkg.sv
// ------------------------------
// Transactions between FMA stages
// Queue depth fixed at two entries
// ------------------------------
`default_nettype none

package fmaTransferPkg;

    localparam int queueDepth    = 2;
    localparam int queuePtrWidth = $clog2(queueDepth);

    typedef logic [queuePtrWidth-1:0] queuePtr;
    typedef logic [queuePtrWidth:0]   queueCount;

    typedef struct packed {
        logic invalid;
        logic overflow;
        logic inexact;
    } fmaFlags;

    typedef struct packed {
        halfFloatPkg::halfWord operandA;
        halfFloatPkg::halfWord operandB;
        halfFloatPkg::halfWord operandC;
        logic                  mulEnable;    // Low means B taken as 1.0
        logic                  addEnable;    // Low means C taken as 0
        logic                  roundNearest; // Low means round to zero
    } fmaRequest;

    typedef struct packed {
        logic                    productSign;
        halfFloatPkg::productExp productExp;
        halfFloatPkg::productSig productSig;
        logic                    productZero;
        logic                    exponentOverflow;
        logic                    cSign;
        halfFloatPkg::expField   cExp;
        halfFloatPkg::sigField   cSig;
        logic                    roundNearest;
        logic                    isSpecial;      // Skip the adder, use specialResult
        halfFloatPkg::halfWord   specialResult;
        fmaFlags                 specialFlags;
    } productRecord;

    typedef struct packed {
        halfFloatPkg::halfWord value;
        fmaFlags               flags;
    } fmaResult;

    typedef enum logic {
        acceptIdle,
        acceptAcked
    } acceptState;

    typedef enum logic [1:0] {
        deliverIdle,
        deliverOffering,
        deliverWaitRelease
    } deliverState;

endpackage

`default_nettype wire

//--- rtl/normalizeRound.sv
// ------------------------------
// Normalize, round RZ or RNE
// Tiny results are not flushed
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module normalizeRound (
    input  logic                    sumSign,
    input  halfFloatPkg::expField   sumExp,
    input  halfFloatPkg::sumSig     sum,
    input  logic                    exponentOverflow,
    input  logic                    roundNearest,
    output halfFloatPkg::halfWord   value,
    output fmaTransferPkg::fmaFlags flags
);

    logic [4:0]          leadPos;
    logic                sumZero;
    halfFloatPkg::sumSig shifted;
    logic [7:0]          normExp, finalExp;
    logic                lsbBit, guardBit, roundBit, stickyBit;
    logic                roundUp;
    logic [11:0]         roundedSig;
    logic [9:0]          roundedFrac;
    logic                overflow, inexact;

    // Highest set bit wins
    always_comb begin
        leadPos = '0;
        for (int i = 0; i < 24; i++) begin
            if (sum[i]) leadPos = 5'(i);
        end
    end

    assign sumZero = ~|sum;
    assign shifted = sum << (5'd23 - leadPos);   // Leading one to bit 23
    assign normExp = 8'(sumExp) + 8'(leadPos) - 8'd21;   // Point sits after bit 21

    assign lsbBit    = shifted[13];
    assign guardBit  = shifted[12];
    assign roundBit  = shifted[11];
    assign stickyBit = |shifted[10:0];

    // Ties go to the even significand
    assign roundUp     = roundNearest & guardBit & (roundBit | stickyBit | lsbBit);
    assign roundedSig  = {1'b0, shifted[23:13]} + 12'(roundUp);
    assign roundedFrac = roundedSig[11] ? roundedSig[10:1] : roundedSig[9:0];
    assign finalExp    = normExp + 8'(roundedSig[11]);

    // Bit 7 set means the exponent went below zero
    assign overflow = exponentOverflow | (~finalExp[7] & (finalExp >= 8'd31));
    assign inexact  = guardBit | roundBit | stickyBit;

    always_comb begin
        flags.invalid = 1'b0;
        if (overflow) begin
            value          = {sumSign, roundNearest ? halfFloatPkg::infMag
                                                    : halfFloatPkg::maxFiniteMag};
            flags.overflow = 1'b1;
            flags.inexact  = 1'b1;
        end else if (sumZero) begin
            value          = {sumSign, 15'b0};   // Sign already resolved upstream
            flags.overflow = 1'b0;
            flags.inexact  = 1'b0;
        end else begin
            value          = {sumSign, finalExp[4:0], roundedFrac};
            flags.overflow = 1'b0;
            flags.inexact  = inexact;
        end
    end

endmodule

`default_nettype wire

//--- rtl/productStage.sv
// ------------------------------
// Accepts requests, forms A * B
// Zero exponent with nonzero fraction
// gets a hidden one anyway
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module productStage (
    input  logic                         clk,
    input  logic                         reset,
    input  fmaTransferPkg::fmaRequest    request,
    input  logic                         req,
    output logic                         ack,
    input  logic                         full,
    output logic                         pushValid,
    output fmaTransferPkg::productRecord pushData
);

    fmaTransferPkg::acceptState state;

    logic                    aSign, bSign, cSign, productSign;
    halfFloatPkg::expField   aExp, bExp, cExp;
    halfFloatPkg::fracField  aFrac, bFrac, cFrac;
    halfFloatPkg::sigField   aSig, bSig, cSig;
    logic [5:0]              expSum;
    halfFloatPkg::productExp prodExp;
    logic                    productZero, expOverflow;
    logic                    aNan, bNan, cNan, anySignaling;
    logic                    zeroTimesInf, mulInf, cInf;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fmaTransferPkg::acceptIdle;
        end else begin
            case (state)
                fmaTransferPkg::acceptIdle:  if (pushValid) state <= fmaTransferPkg::acceptAcked;
                fmaTransferPkg::acceptAcked: if (!req) state <= fmaTransferPkg::acceptIdle;
                default:                     state <= fmaTransferPkg::acceptIdle;
            endcase
        end
    end

    assign ack       = (state == fmaTransferPkg::acceptAcked);
    assign pushValid = (state == fmaTransferPkg::acceptIdle) & req & ~full;

    // Disabled multiply turns B into 1.0, disabled add turns C into 0
    assign aSign = request.operandA[15];
    assign bSign = request.mulEnable & request.operandB[15];
    assign cSign = request.addEnable & request.operandC[15];
    assign aExp  = request.operandA[14:10];
    assign bExp  = request.mulEnable ? request.operandB[14:10]
                                     : halfFloatPkg::expField'(halfFloatPkg::expBias);
    assign cExp  = request.addEnable ? request.operandC[14:10] : '0;
    assign aFrac = request.operandA[9:0];
    assign bFrac = request.mulEnable ? request.operandB[9:0] : '0;
    assign cFrac = request.addEnable ? request.operandC[9:0] : '0;

    assign aSig = {1'b1, aFrac};
    assign bSig = {1'b1, bFrac};
    assign cSig = {|{cExp, cFrac}, cFrac};   // Hidden one unless C is zero

    assign productSign = aSign ^ bSign;
    assign productZero = ((aExp == '0) & (aFrac == '0)) | ((bExp == '0) & (bFrac == '0));
    assign expSum      = {1'b0, aExp} + {1'b0, bExp};
    assign prodExp     = productZero ? '0 : expSum - 6'(halfFloatPkg::expBias);
    assign expOverflow = prodExp[5] & expSum[5];   // Wrapped past 31, not negative

    assign aNan         = (&aExp) & (|aFrac);
    assign bNan         = (&bExp) & (|bFrac);
    assign cNan         = (&cExp) & (|cFrac);
    assign anySignaling = (aNan & ~aFrac[9]) | (bNan & ~bFrac[9]) | (cNan & ~cFrac[9]);
    assign zeroTimesInf = (aFrac == '0) & (bFrac == '0)
                        & (((aExp == '0) & (&bExp)) | ((bExp == '0) & (&aExp)));
    assign mulInf       = (&aExp) | (&bExp);
    assign cInf         = (&cExp) & (cFrac == '0);

    always_comb begin
        pushData.productSign      = productSign;
        pushData.productExp       = prodExp;
        pushData.productSig       = productZero ? '0 : aSig * bSig;
        pushData.productZero      = productZero;
        pushData.exponentOverflow = expOverflow;
        pushData.cSign            = cSign;
        pushData.cExp             = cExp;
        pushData.cSig             = cSig;
        pushData.roundNearest     = request.roundNearest;
        pushData.isSpecial        = 1'b1;
        pushData.specialResult    = halfFloatPkg::quietNan;
        pushData.specialFlags     = '0;

        // Priority matters, NaN checks come before infinity checks
        if (zeroTimesInf) begin
            pushData.specialFlags.invalid = 1'b1;
        end else if (aNan | bNan | cNan) begin
            pushData.specialFlags.invalid = anySignaling;
        end else if (mulInf) begin
            if ((&cExp) & (productSign ^ cSign)) begin
                pushData.specialFlags.invalid = 1'b1;   // Inf minus inf
            end else begin
                pushData.specialResult = {productSign, halfFloatPkg::infMag};
            end
        end else if (cInf) begin
            pushData.specialResult = {cSign, halfFloatPkg::infMag};
        end else begin
            pushData.isSpecial = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/productQueue.sv
// ------------------------------
// Product FIFO, no write when full
// Head readable while not empty
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module productQueue (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         pushValid,
    input  fmaTransferPkg::productRecord pushData,
    output logic                         full,
    input  logic                         popReady,
    output fmaTransferPkg::productRecord popData,
    output logic                         notEmpty
);

    fmaTransferPkg::productRecord entries [fmaTransferPkg::queueDepth];

    fmaTransferPkg::queuePtr   wrPtr, rdPtr;
    fmaTransferPkg::queueCount count;
    logic                      pushAccept, popAccept;

    assign pushAccept = pushValid & ~full;
    assign popAccept  = popReady & notEmpty;

    always_ff @(posedge clk) begin
        if (pushAccept) entries[wrPtr] <= pushData;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushAccept) begin
                wrPtr <= (wrPtr == fmaTransferPkg::queuePtr'(fmaTransferPkg::queueDepth - 1))
                       ? '0 : wrPtr + 1'b1;
            end
            if (popAccept) begin
                rdPtr <= (rdPtr == fmaTransferPkg::queuePtr'(fmaTransferPkg::queueDepth - 1))
                       ? '0 : rdPtr + 1'b1;
            end
            case ({pushAccept, popAccept})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    assign full     = (count == fmaTransferPkg::queueCount'(fmaTransferPkg::queueDepth));
    assign notEmpty = (count != '0);
    assign popData  = entries[rdPtr];

endmodule

`default_nettype wire

//--- rtl/sumStage.sv
// ------------------------------
// Adds C to the product, delivers
// One result offered at a time
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module sumStage (
    input  logic                         clk,
    input  logic                         reset,
    input  fmaTransferPkg::productRecord popData,
    input  logic                         notEmpty,
    output logic                         popReady,
    output fmaTransferPkg::fmaResult     result,
    output logic                         resultReq,
    input  logic                         resultAck
);

    fmaTransferPkg::deliverState state;

    logic [6:0]              expDiff, shiftP, shiftC;
    logic                    productGreater, effSub;
    logic [22:0]             alignedP, alignedC;
    halfFloatPkg::sumSig     addSum, subPC, subCP, magnitude;
    logic                    sumSign;
    halfFloatPkg::expField   sumExp;
    halfFloatPkg::halfWord   roundedValue;
    fmaTransferPkg::fmaFlags roundedFlags;

    // Right shift keeping a sticky bit for everything shifted out
    function automatic logic [22:0] alignRight(input halfFloatPkg::productSig value,
                                               input logic [6:0] shamt);
        logic [43:0] wide;
        logic        sticky;
        wide   = {value, 22'b0} >> shamt;
        sticky = (|wide[21:0]) | ((shamt > 7'd42) & (|value));
        return {wide[43:22], sticky};
    endfunction

    assign expDiff        = {popData.productExp[5], popData.productExp} - {2'b00, popData.cExp};
    assign productGreater = popData.exponentOverflow | (~popData.productZero & ~expDiff[6]);
    assign shiftC         = productGreater ? expDiff : '0;
    assign shiftP         = productGreater ? '0 : ~expDiff + 7'd1;
    assign sumExp         = productGreater ? popData.productExp[4:0] : popData.cExp;

    // C placed in the product frame, point after bit 20
    assign alignedP = alignRight(popData.productSig, shiftP);
    assign alignedC = alignRight({1'b0, popData.cSig, 10'b0}, shiftC);

    assign effSub = popData.productSign ^ popData.cSign;
    assign addSum = {1'b0, alignedP} + {1'b0, alignedC};
    assign subPC  = {1'b0, alignedP} - {1'b0, alignedC};
    assign subCP  = {1'b0, alignedC} - {1'b0, alignedP};

    always_comb begin
        if (!effSub) begin
            magnitude = addSum;
            sumSign   = popData.productSign;   // Two -0 operands stay -0
        end else if (subPC[23] & ~popData.exponentOverflow) begin
            magnitude = subCP;                 // C was larger
            sumSign   = popData.cSign;
        end else begin
            magnitude = subPC;
            sumSign   = ((subPC == '0) & ~popData.exponentOverflow) ? 1'b0 : popData.productSign;
        end
    end

    normalizeRound u_normalizeRound (
        .sumSign,
        .sumExp,
        .sum              (magnitude),
        .exponentOverflow (popData.exponentOverflow),
        .roundNearest     (popData.roundNearest),
        .value            (roundedValue),
        .flags            (roundedFlags)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fmaTransferPkg::deliverIdle;
        end else begin
            case (state)
                fmaTransferPkg::deliverIdle:
                    if (notEmpty) state <= fmaTransferPkg::deliverOffering;
                fmaTransferPkg::deliverOffering:
                    if (resultAck) state <= fmaTransferPkg::deliverWaitRelease;
                fmaTransferPkg::deliverWaitRelease:
                    if (!resultAck) state <= fmaTransferPkg::deliverIdle;
                default:
                    state <= fmaTransferPkg::deliverIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (popReady & notEmpty) begin
            if (popData.isSpecial) begin
                result.value <= popData.specialResult;
                result.flags <= popData.specialFlags;
            end else begin
                result.value <= roundedValue;
                result.flags <= roundedFlags;
            end
        end
    end

    assign popReady  = (state == fmaTransferPkg::deliverIdle);
    assign resultReq = (state == fmaTransferPkg::deliverOffering);

endmodule

`default_nettype wire

//--- rtl/fmaUnit.sv
// ------------------------------
// Half-precision A * B + C
// Four-phase req/ack on both sides
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module fmaUnit (
    input  logic                      clk,
    input  logic                      reset,
    input  fmaTransferPkg::fmaRequest request,
    input  logic                      req,
    output logic                      ack,
    output fmaTransferPkg::fmaResult  result,
    output logic                      resultReq,
    input  logic                      resultAck
);

    logic                         full;
    logic                         pushValid;
    fmaTransferPkg::productRecord pushData;
    logic                         popReady;
    fmaTransferPkg::productRecord popData;
    logic                         notEmpty;

    productStage u_productStage (
        .clk, .reset,
        .request, .req, .ack,
        .full, .pushValid, .pushData
    );

    // Decouples accept rate from delivery rate
    productQueue u_productQueue (
        .clk, .reset,
        .pushValid, .pushData, .full,
        .popReady, .popData, .notEmpty
    );

    sumStage u_sumStage (
        .clk, .reset,
        .popData, .notEmpty, .popReady,
        .result, .resultReq, .resultAck
    );

endmodule

`default_nettype wire

//--- tb/fmaUnit_assertions.sv
// ------------------------------
// Handshake checks on fmaUnit
// Bound inside the DUT, reset masks all
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module fmaUnit_assertions (
    input logic                     clk,
    input logic                     reset,
    input logic                     req,
    input logic                     ack,
    input fmaTransferPkg::fmaResult result,
    input logic                     resultReq,
    input logic                     resultAck
);

    // Acceptance only answers a pending request
    ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    resultReqHolds: assert property (@(posedge clk) disable iff (reset)
        (resultReq && !resultAck) |=> resultReq)
        else $error("resultReq dropped before resultAck");

    // Offered result must not move under the consumer
    resultStable: assert property (@(posedge clk) disable iff (reset)
        (resultReq && $past(resultReq)) |-> $stable(result))
        else $error("result changed while resultReq was high");

endmodule

`default_nettype wire

//--- tb/fmaUnit_tb.sv
// ------------------------------
// Directed tests for fmaUnit
// Normal operands only, no subnormals
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module fmaUnit_tb;

    localparam int clkPeriod            = 40;
    localparam int transactionCount     = 17;
    localparam int cyclesPerTransaction = 40;
    localparam int marginCycles         = 100;
    localparam int watchdogCycles = transactionCount * cyclesPerTransaction + marginCycles;

    // Order is invalid, overflow, inexact
    localparam fmaTransferPkg::fmaFlags noFlags         = 3'b000;
    localparam fmaTransferPkg::fmaFlags inexactOnly     = 3'b001;
    localparam fmaTransferPkg::fmaFlags overflowInexact = 3'b011;
    localparam fmaTransferPkg::fmaFlags invalidOnly     = 3'b100;

    logic                      clk = 1'b0;
    logic                      reset;
    fmaTransferPkg::fmaRequest request;
    logic                      req;
    logic                      ack;
    fmaTransferPkg::fmaResult  result;
    logic                      resultReq;
    logic                      resultAck;

    int valueErrors    = 0;
    int flagErrors     = 0;
    int protocolErrors = 0;
    int sentCount      = 0;

    fmaUnit u_dut (
        .clk, .reset,
        .request, .req, .ack,
        .result, .resultReq, .resultAck
    );

    bind fmaUnit fmaUnit_assertions u_assertions (
        .clk, .reset, .req, .ack,
        .result, .resultReq, .resultAck
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic fmaTransferPkg::fmaRequest buildRequest(
        input halfFloatPkg::halfWord a, b, c,
        input logic mulOn, addOn, nearest);
        fmaTransferPkg::fmaRequest r;
        r.operandA     = a;
        r.operandB     = b;
        r.operandC     = c;
        r.mulEnable    = mulOn;
        r.addEnable    = addOn;
        r.roundNearest = nearest;
        return r;
    endfunction

    task automatic compareValue(input string name, input halfFloatPkg::halfWord expected,
                                input halfFloatPkg::halfWord actual);
        if (actual !== expected) begin
            $display("[ERROR] %s result.value expected 0x%h got 0x%h", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic compareFlags(input string name, input fmaTransferPkg::fmaFlags expected,
                                input fmaTransferPkg::fmaFlags actual);
        if (actual !== expected) begin
            $display("[ERROR] %s result.flags expected 0x%h got 0x%h", name, expected, actual);
            flagErrors++;
        end
    endtask

    // Full four-phase cycle on the input side
    task automatic sendRequest(input fmaTransferPkg::fmaRequest r);
        @(posedge clk);
        request <= r;
        req     <= 1'b1;
        @(negedge clk);
        while (!ack) @(negedge clk);
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (ack) @(negedge clk);
    endtask

    task automatic collectResult(output fmaTransferPkg::fmaResult got);
        @(negedge clk);
        while (!resultReq) @(negedge clk);
        got = result;
        @(posedge clk);
        resultAck <= 1'b1;
        @(negedge clk);
        while (resultReq) @(negedge clk);
        @(posedge clk);
        resultAck <= 1'b0;
    endtask

    task automatic runTest(input string name, input fmaTransferPkg::fmaRequest r,
                           input halfFloatPkg::halfWord expValue,
                           input fmaTransferPkg::fmaFlags expFlags);
        fmaTransferPkg::fmaResult got;
        sendRequest(r);
        collectResult(got);
        compareValue(name, expValue, got.value);
        compareFlags(name, expFlags, got.flags);
    endtask

    task automatic testExactAndEnables();
        runTest("1*2+0.5", buildRequest(16'h3C00, 16'h4000, 16'h3800, 1, 1, 1),
                16'h4100, noFlags);
        runTest("3 pass", buildRequest(16'h4200, 16'h1234, 16'h5678, 0, 0, 0),
                16'h4200, noFlags);   // B and C ignored
        runTest("2*1.5-1", buildRequest(16'h4000, 16'h3E00, 16'hBC00, 1, 1, 1),
                16'h4000, noFlags);
    endtask

    task automatic testRoundingModes();
        // Exact tie, odd lsb
        runTest("tie rz", buildRequest(16'h3E00, 16'h3C01, 16'h0000, 1, 0, 0),
                16'h3E01, inexactOnly);
        runTest("tie rne", buildRequest(16'h3E00, 16'h3C01, 16'h0000, 1, 0, 1),
                16'h3E02, inexactOnly);
    endtask

    task automatic testCancellation();
        runTest("cancel rz", buildRequest(16'h3C00, 16'h3C00, 16'hBC00, 1, 1, 0),
                16'h0000, noFlags);
        runTest("cancel rne", buildRequest(16'h3C00, 16'h3C00, 16'hBC00, 1, 1, 1),
                16'h0000, noFlags);
    endtask

    task automatic testOverflow();
        runTest("ovf rz", buildRequest(16'h7800, 16'h7800, 16'h0000, 1, 0, 0),
                16'h7BFF, overflowInexact);
        runTest("ovf rne", buildRequest(16'h7800, 16'h7800, 16'h0000, 1, 0, 1),
                16'h7C00, overflowInexact);
    endtask

    task automatic testSpecialCases();
        runTest("snan", buildRequest(16'h7D00, 16'h3C00, 16'h0000, 1, 0, 1),
                16'h7E00, invalidOnly);
        runTest("0*inf", buildRequest(16'h0000, 16'h7C00, 16'h0000, 1, 0, 1),
                16'h7E00, invalidOnly);
        runTest("inf-inf", buildRequest(16'h7C00, 16'h3C00, 16'hFC00, 1, 1, 1),
                16'h7E00, invalidOnly);
        runTest("2-inf", buildRequest(16'h4000, 16'h0000, 16'hFC00, 0, 1, 1),
                16'hFC00, noFlags);
    endtask

    // Three fit in flight, the fourth must wait
    task automatic testBackPressure();
        fmaTransferPkg::fmaRequest reqs [4];
        halfFloatPkg::halfWord     expValues [4];
        fmaTransferPkg::fmaFlags   expFlags [4];
        fmaTransferPkg::fmaResult  got;
        int                        delayCycles;

        reqs[0] = buildRequest(16'h3C00, 16'h4000, 16'h3800, 1, 1, 1);
        reqs[1] = buildRequest(16'h3E00, 16'h3C01, 16'h0000, 1, 0, 1);
        reqs[2] = buildRequest(16'h7800, 16'h7800, 16'h0000, 1, 0, 0);
        reqs[3] = buildRequest(16'h0000, 16'h7C00, 16'h0000, 1, 0, 1);
        expValues = '{16'h4100, 16'h3E02, 16'h7BFF, 16'h7E00};
        expFlags  = '{noFlags, inexactOnly, overflowInexact, invalidOnly};
        sentCount = 0;

        fork
            begin
                for (int i = 0; i < 4; i++) begin
                    sendRequest(reqs[i]);
                    sentCount++;
                end
            end
            begin
                wait (sentCount == 3);
                repeat (4) @(negedge clk);
                if (!req || ack) begin
                    $display("Fourth request was not held off while the queue was full");
                    protocolErrors++;
                end
                for (int i = 0; i < 4; i++) begin
                    delayCycles = $urandom_range(0, 5);
                    repeat (delayCycles) @(posedge clk);
                    collectResult(got);
                    compareValue($sformatf("ordered %0d", i), expValues[i], got.value);
                    compareFlags($sformatf("ordered %0d", i), expFlags[i], got.flags);
                end
            end
        join

        // A repeated result would show up here
        repeat (6) begin
            @(negedge clk);
            if (resultReq) begin
                $display("Unexpected extra result offered after all four were taken");
                protocolErrors++;
            end
        end
    endtask

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Watchdog expired at %0t, a handshake never completed", $time);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h2e01_b45d));
        reset     = 1'b1;
        req       = 1'b0;
        resultAck = 1'b0;
        request   = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        testExactAndEnables();
        testRoundingModes();
        testCancellation();
        testOverflow();
        testSpecialCases();
        testBackPressure();

        $display("Errors: value %0d, flags %0d, protocol %0d",
                 valueErrors, flagErrors, protocolErrors);
        if (valueErrors + flagErrors + protocolErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/halfFloatPkg.sv
rtl/fmaTransferPkg.sv
rtl/normalizeRound.sv
rtl/productStage.sv
rtl/productQueue.sv
rtl/sumStage.sv
rtl/fmaUnit.sv
tb/fmaUnit_assertions.sv
tb/fmaUnit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the FMA testbench with Verilator and runs it.
# A crash or a failure line in the log gives a nonzero exit status.
set -e
set -o pipefail

cd "$(dirname "$0")"

buildDir=obj_dir
logFile=sim.log

verilator --binary --assert -j 0 \
    --top-module fmaUnit_tb \
    -f vlog.f \
    --Mdir "$buildDir" \
    -o fmaUnit_sim

"./$buildDir/fmaUnit_sim" | tee "$logFile"

if grep -q "Testbench failed" "$logFile"; then
    echo "Simulation reported a failure, see $logFile"
    exit 1
fi

echo "Simulation finished, no failure found in $logFile"
